// ==== build.f ====
hdl/fwd_pkg.sv
hdl/hdr_parser.sv
hdl/pkt_fifo.sv
hdl/fwd_action.sv
hdl/p4_fwd_top.sv
verif/p4_fwd_asserts.sv
verif/p4_fwd_tb.sv

// ==== hdl/fwd_action.sv ====
// Action table lookup and output register for the forwarding stage
// Table is looked up on the head beat only; writes must not overlap traffic
`timescale 1ns/10ps

module fwd_action #(
   parameter int TDATA_NUM_BYTES = fwd_pkg::TDATA_NUM_BYTES,
   parameter int KEY_BITS        = fwd_pkg::KEY_BITS
) (
   input  logic                              axis_aclk,
   input  logic                              arst_n,
   // FIFO read side
   input  logic                              rd_valid,
   input  logic [TDATA_NUM_BYTES*8-1:0]      rd_data,
   input  logic [TDATA_NUM_BYTES-1:0]        rd_keep,
   input  logic                              rd_last,
   input  logic [KEY_BITS-1:0]               rd_key,
   input  logic [fwd_pkg::META_IN_BITS-1:0]  rd_meta,
   input  logic                              rd_first,
   output logic                              rd_ready,
   // Table write strobe
   input  logic                              table_wr_en,
   input  logic [KEY_BITS-1:0]               table_wr_addr,
   input  fwd_pkg::fwd_action_e              table_wr_action,
   input  logic [fwd_pkg::PORT_BITS-1:0]     table_wr_port,
   // Egress stream
   output logic [TDATA_NUM_BYTES*8-1:0]      m_axis_tdata,
   output logic [TDATA_NUM_BYTES-1:0]        m_axis_tkeep,
   output logic                              m_axis_tlast,
   output logic                              m_axis_tvalid,
   input  logic                              m_axis_tready,
   // Egress metadata, with the first output beat
   output logic [fwd_pkg::META_OUT_BITS-1:0] user_metadata_out,
   output logic                              user_metadata_out_valid
);

   import fwd_pkg::*;

   localparam int TBL_SIZE = 2 ** KEY_BITS;

   logic [ENTRY_BITS-1:0]        tbl [TBL_SIZE];
   logic [ENTRY_BITS-1:0]        entry;
   parse_state_e                 state;
   fwd_action_e                  act_q;
   logic [PORT_BITS-1:0]         port_q;
   fwd_action_e                  cur_action;
   logic [PORT_BITS-1:0]         cur_port;
   logic [TDATA_NUM_BYTES*8-1:0] out_data;
   logic                         out_free;
   logic                         pop;
   logic                         send;

   // --------------------
   // Action table, all entries drop after reset
   always_ff @(posedge axis_aclk or negedge arst_n) begin
      if (!arst_n) begin
         for (int i = 0; i < TBL_SIZE; i++) begin
            tbl[i] <= {ACT_DROP, {PORT_BITS{1'b0}}};
         end
      end else if (table_wr_en) begin
         tbl[table_wr_addr] <= {table_wr_action, table_wr_port};
      end
   end

   // Head beat reads the table, body beats reuse the latched result
   assign entry      = tbl[rd_key];
   assign cur_action = (state == ST_HEAD) ? fwd_action_e'(entry[ENTRY_BITS-1:PORT_BITS]) : act_q;
   assign cur_port   = (state == ST_HEAD) ? entry[PORT_BITS-1:0] : port_q;

   // --------------------
   // Pop control

   // Output register free when empty or being taken
   assign out_free = !m_axis_tvalid || m_axis_tready;
   // Dropped beats drain one per cycle regardless of the output
   assign rd_ready = (cur_action == ACT_DROP) || out_free;
   assign pop      = rd_valid && rd_ready;
   assign send     = pop && (cur_action != ACT_DROP);

   // Rewrite touches only the key bits of byte 0 on the first beat
   always_comb begin
      out_data = rd_data;
      if (cur_action == ACT_REWRITE && rd_first) begin
         out_data[KEY_BITS-1:0] = KEY_BITS'(cur_port);
      end
   end

   // --------------------
   // Framing, latched action and output valids
   always_ff @(posedge axis_aclk or negedge arst_n) begin
      if (!arst_n) begin
         state                   <= ST_HEAD;
         act_q                   <= ACT_DROP;
         m_axis_tvalid           <= 1'b0;
         user_metadata_out_valid <= 1'b0;
      end else begin
         if (pop) begin
            state <= rd_last ? ST_HEAD : ST_BODY;
            act_q <= cur_action;
         end
         if (send) begin
            m_axis_tvalid           <= 1'b1;
            user_metadata_out_valid <= rd_first;
         end else if (m_axis_tready) begin
            m_axis_tvalid           <= 1'b0;
            user_metadata_out_valid <= 1'b0;
         end
      end
   end

   // Output payload
   always_ff @(posedge axis_aclk) begin
      if (pop) port_q <= cur_port;
      if (send) begin
         m_axis_tdata      <= out_data;
         m_axis_tkeep      <= rd_keep;
         m_axis_tlast      <= rd_last;
         user_metadata_out <= {cur_port, rd_meta};
      end
   end

endmodule

// ==== hdl/fwd_pkg.sv ====
// Shared widths and encodings for the forwarding pipeline
// KEY_BITS must not exceed 8, since the key lives in byte 0 of the head beat
package fwd_pkg;

   // --------------------
   // Default widths, overridden from the top level
   localparam int TDATA_NUM_BYTES = 4;
   localparam int KEY_BITS        = 4;

   // Fixed sideband widths
   localparam int PORT_BITS     = 4;
   localparam int META_IN_BITS  = 8;
   // Egress port on top, ingress metadata below
   localparam int META_OUT_BITS = PORT_BITS + META_IN_BITS;

   // --------------------
   // Table actions, drop is the reset value
   typedef enum logic [1:0] {
      ACT_DROP    = 2'd0,
      ACT_FORWARD = 2'd1,
      ACT_REWRITE = 2'd2
   } fwd_action_e;

   // Packet framing
   typedef enum logic {
      ST_HEAD = 1'b0,
      ST_BODY = 1'b1
   } parse_state_e;

   // Table entry is {action, port}
   localparam int ENTRY_BITS = $bits(fwd_action_e) + PORT_BITS;

endpackage

// ==== hdl/hdr_parser.sv ====
// One-beat register slice that tags each beat with key and ingress metadata
// Key is the low KEY_BITS of byte 0 of the head beat; KEY_BITS must be 8 or less
`timescale 1ns/10ps

module hdr_parser #(
   parameter int TDATA_NUM_BYTES = fwd_pkg::TDATA_NUM_BYTES,
   parameter int KEY_BITS        = fwd_pkg::KEY_BITS
) (
   input  logic                             axis_aclk,
   input  logic                             arst_n,
   // Ingress stream
   input  logic [TDATA_NUM_BYTES*8-1:0]     s_axis_tdata,
   input  logic [TDATA_NUM_BYTES-1:0]       s_axis_tkeep,
   input  logic                             s_axis_tlast,
   input  logic                             s_axis_tvalid,
   output logic                             s_axis_tready,
   // Ingress metadata, taken with the head beat
   input  logic [fwd_pkg::META_IN_BITS-1:0] user_metadata_in,
   input  logic                             user_metadata_in_valid,
   // FIFO write side
   output logic                             wr_valid,
   output logic [TDATA_NUM_BYTES*8-1:0]     wr_data,
   output logic [TDATA_NUM_BYTES-1:0]       wr_keep,
   output logic                             wr_last,
   output logic [KEY_BITS-1:0]              wr_key,
   output logic [fwd_pkg::META_IN_BITS-1:0] wr_meta,
   output logic                             wr_first,
   input  logic                             wr_ready
);

   import fwd_pkg::*;

   parse_state_e            state;
   logic                    accept;
   logic [META_IN_BITS-1:0] meta_in;

   // --------------------
   // Handshake

   // Room when the slice is empty or its beat drains this cycle
   assign s_axis_tready = !wr_valid || wr_ready;
   assign accept        = s_axis_tvalid && s_axis_tready;

   // No metadata strobe on the head beat reads as zero
   assign meta_in = user_metadata_in_valid ? user_metadata_in : '0;

   // --------------------
   // Framing and valid

   always_ff @(posedge axis_aclk or negedge arst_n) begin
      if (!arst_n) begin
         state    <= ST_HEAD;
         wr_valid <= 1'b0;
      end else begin
         if (accept) begin
            wr_valid <= 1'b1;
            // Next beat opens a new packet after tlast
            state    <= s_axis_tlast ? ST_HEAD : ST_BODY;
         end else if (wr_ready) begin
            wr_valid <= 1'b0;
         end
      end
   end

   // --------------------
   // Beat register

   always_ff @(posedge axis_aclk) begin
      if (accept) begin
         wr_data  <= s_axis_tdata;
         wr_keep  <= s_axis_tkeep;
         wr_last  <= s_axis_tlast;
         wr_first <= (state == ST_HEAD);
         // Key and metadata held unchanged through body beats
         if (state == ST_HEAD) begin
            wr_key  <= s_axis_tdata[KEY_BITS-1:0];
            wr_meta <= meta_in;
         end
      end
   end

endmodule

// ==== hdl/p4_fwd_top.sv ====
// Parser, packet FIFO and forwarding stage on the single axis_aclk domain
// Minimum latency is 3 cycles from input handshake to m_axis_tvalid
`timescale 1ns/10ps

module p4_fwd_top #(
   parameter int TDATA_NUM_BYTES = fwd_pkg::TDATA_NUM_BYTES,
   parameter int KEY_BITS        = fwd_pkg::KEY_BITS,
   parameter int FIFO_DEPTH      = 16
) (
   input  logic                              axis_aclk,
   input  logic                              arst_n,
   // Ingress metadata
   input  logic [fwd_pkg::META_IN_BITS-1:0]  user_metadata_in,
   input  logic                              user_metadata_in_valid,
   // Slave stream
   input  logic [TDATA_NUM_BYTES*8-1:0]      s_axis_tdata,
   input  logic [TDATA_NUM_BYTES-1:0]        s_axis_tkeep,
   input  logic                              s_axis_tlast,
   input  logic                              s_axis_tvalid,
   output logic                              s_axis_tready,
   // Master stream
   output logic [TDATA_NUM_BYTES*8-1:0]      m_axis_tdata,
   output logic [TDATA_NUM_BYTES-1:0]        m_axis_tkeep,
   output logic                              m_axis_tlast,
   output logic                              m_axis_tvalid,
   input  logic                              m_axis_tready,
   // Egress metadata
   output logic [fwd_pkg::META_OUT_BITS-1:0] user_metadata_out,
   output logic                              user_metadata_out_valid,
   // Table write
   input  logic                              table_wr_en,
   input  logic [KEY_BITS-1:0]               table_wr_addr,
   input  fwd_pkg::fwd_action_e              table_wr_action,
   input  logic [fwd_pkg::PORT_BITS-1:0]     table_wr_port
);

   // --------------------
   // Parser to FIFO
   logic                             wr_valid;
   logic                             wr_ready;
   logic [TDATA_NUM_BYTES*8-1:0]     wr_data;
   logic [TDATA_NUM_BYTES-1:0]       wr_keep;
   logic                             wr_last;
   logic [KEY_BITS-1:0]              wr_key;
   logic [fwd_pkg::META_IN_BITS-1:0] wr_meta;
   logic                             wr_first;

   // FIFO to forwarding stage
   logic                             rd_valid;
   logic                             rd_ready;
   logic [TDATA_NUM_BYTES*8-1:0]     rd_data;
   logic [TDATA_NUM_BYTES-1:0]       rd_keep;
   logic                             rd_last;
   logic [KEY_BITS-1:0]              rd_key;
   logic [fwd_pkg::META_IN_BITS-1:0] rd_meta;
   logic                             rd_first;

   hdr_parser #(
      .TDATA_NUM_BYTES (TDATA_NUM_BYTES),
      .KEY_BITS        (KEY_BITS)
   ) hdr_parser_inst (
      .axis_aclk              (axis_aclk),
      .arst_n                 (arst_n),
      .s_axis_tdata           (s_axis_tdata),
      .s_axis_tkeep           (s_axis_tkeep),
      .s_axis_tlast           (s_axis_tlast),
      .s_axis_tvalid          (s_axis_tvalid),
      .s_axis_tready          (s_axis_tready),
      .user_metadata_in       (user_metadata_in),
      .user_metadata_in_valid (user_metadata_in_valid),
      .wr_valid               (wr_valid),
      .wr_data                (wr_data),
      .wr_keep                (wr_keep),
      .wr_last                (wr_last),
      .wr_key                 (wr_key),
      .wr_meta                (wr_meta),
      .wr_first               (wr_first),
      .wr_ready               (wr_ready)
   );

   pkt_fifo #(
      .TDATA_NUM_BYTES (TDATA_NUM_BYTES),
      .KEY_BITS        (KEY_BITS),
      .FIFO_DEPTH      (FIFO_DEPTH)
   ) pkt_fifo_inst (
      .axis_aclk (axis_aclk),
      .arst_n    (arst_n),
      .wr_valid  (wr_valid),
      .wr_data   (wr_data),
      .wr_keep   (wr_keep),
      .wr_last   (wr_last),
      .wr_key    (wr_key),
      .wr_meta   (wr_meta),
      .wr_first  (wr_first),
      .wr_ready  (wr_ready),
      .rd_valid  (rd_valid),
      .rd_data   (rd_data),
      .rd_keep   (rd_keep),
      .rd_last   (rd_last),
      .rd_key    (rd_key),
      .rd_meta   (rd_meta),
      .rd_first  (rd_first),
      .rd_ready  (rd_ready)
   );

   fwd_action #(
      .TDATA_NUM_BYTES (TDATA_NUM_BYTES),
      .KEY_BITS        (KEY_BITS)
   ) fwd_action_inst (
      .axis_aclk               (axis_aclk),
      .arst_n                  (arst_n),
      .rd_valid                (rd_valid),
      .rd_data                 (rd_data),
      .rd_keep                 (rd_keep),
      .rd_last                 (rd_last),
      .rd_key                  (rd_key),
      .rd_meta                 (rd_meta),
      .rd_first                (rd_first),
      .rd_ready                (rd_ready),
      .table_wr_en             (table_wr_en),
      .table_wr_addr           (table_wr_addr),
      .table_wr_action         (table_wr_action),
      .table_wr_port           (table_wr_port),
      .m_axis_tdata            (m_axis_tdata),
      .m_axis_tkeep            (m_axis_tkeep),
      .m_axis_tlast            (m_axis_tlast),
      .m_axis_tvalid           (m_axis_tvalid),
      .m_axis_tready           (m_axis_tready),
      .user_metadata_out       (user_metadata_out),
      .user_metadata_out_valid (user_metadata_out_valid)
   );

endmodule

// ==== hdl/pkt_fifo.sv ====
// First-word-fall-through FIFO of tagged beats, FIFO_DEPTH of 2 or more
// Head entry is always on the read side; a write is visible the next cycle
`timescale 1ns/10ps

module pkt_fifo #(
   parameter int TDATA_NUM_BYTES = fwd_pkg::TDATA_NUM_BYTES,
   parameter int KEY_BITS        = fwd_pkg::KEY_BITS,
   parameter int FIFO_DEPTH      = 16
) (
   input  logic                             axis_aclk,
   input  logic                             arst_n,
   // Write side
   input  logic                             wr_valid,
   input  logic [TDATA_NUM_BYTES*8-1:0]     wr_data,
   input  logic [TDATA_NUM_BYTES-1:0]       wr_keep,
   input  logic                             wr_last,
   input  logic [KEY_BITS-1:0]              wr_key,
   input  logic [fwd_pkg::META_IN_BITS-1:0] wr_meta,
   input  logic                             wr_first,
   output logic                             wr_ready,
   // Read side
   output logic                             rd_valid,
   output logic [TDATA_NUM_BYTES*8-1:0]     rd_data,
   output logic [TDATA_NUM_BYTES-1:0]       rd_keep,
   output logic                             rd_last,
   output logic [KEY_BITS-1:0]              rd_key,
   output logic [fwd_pkg::META_IN_BITS-1:0] rd_meta,
   output logic                             rd_first,
   input  logic                             rd_ready
);

   import fwd_pkg::*;

   localparam int PTR_BITS = $clog2(FIFO_DEPTH);
   localparam int CNT_BITS = $clog2(FIFO_DEPTH + 1);

   // Storage, one array per field
   logic [TDATA_NUM_BYTES*8-1:0] data_mem  [FIFO_DEPTH];
   logic [TDATA_NUM_BYTES-1:0]   keep_mem  [FIFO_DEPTH];
   logic                         last_mem  [FIFO_DEPTH];
   logic [KEY_BITS-1:0]          key_mem   [FIFO_DEPTH];
   logic [META_IN_BITS-1:0]      meta_mem  [FIFO_DEPTH];
   logic                         first_mem [FIFO_DEPTH];

   logic [PTR_BITS-1:0] wr_ptr;
   logic [PTR_BITS-1:0] rd_ptr;
   logic [CNT_BITS-1:0] count;
   logic                push;
   logic                pop;

   // Wraps at FIFO_DEPTH, so any depth works
   function automatic logic [PTR_BITS-1:0] next_ptr(input logic [PTR_BITS-1:0] ptr);
      return (ptr == PTR_BITS'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
   endfunction

   // --------------------
   // Flags
   assign wr_ready = (count != CNT_BITS'(FIFO_DEPTH));
   assign rd_valid = (count != '0);
   assign push     = wr_valid && wr_ready;
   assign pop      = rd_valid && rd_ready;

   // Head entry falls through
   assign rd_data  = data_mem[rd_ptr];
   assign rd_keep  = keep_mem[rd_ptr];
   assign rd_last  = last_mem[rd_ptr];
   assign rd_key   = key_mem[rd_ptr];
   assign rd_meta  = meta_mem[rd_ptr];
   assign rd_first = first_mem[rd_ptr];

   // --------------------
   // Pointers and occupancy
   always_ff @(posedge axis_aclk or negedge arst_n) begin
      if (!arst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) wr_ptr <= next_ptr(wr_ptr);
         if (pop)  rd_ptr <= next_ptr(rd_ptr);
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // Write port
   always_ff @(posedge axis_aclk) begin
      if (push) begin
         data_mem[wr_ptr]  <= wr_data;
         keep_mem[wr_ptr]  <= wr_keep;
         last_mem[wr_ptr]  <= wr_last;
         key_mem[wr_ptr]   <= wr_key;
         meta_mem[wr_ptr]  <= wr_meta;
         first_mem[wr_ptr] <= wr_first;
      end
   end

endmodule

// ==== verif/p4_fwd_asserts.sv ====
// Concurrent checks on the egress stream of p4_fwd_top, attached by bind
// First-beat tracking assumes the stream starts on a packet boundary after reset
`timescale 1ns/10ps

module p4_fwd_asserts #(
   parameter int TDATA_NUM_BYTES = fwd_pkg::TDATA_NUM_BYTES
) (
   input logic                              axis_aclk,
   input logic                              arst_n,
   input logic [TDATA_NUM_BYTES*8-1:0]      m_axis_tdata,
   input logic [TDATA_NUM_BYTES-1:0]        m_axis_tkeep,
   input logic                              m_axis_tlast,
   input logic                              m_axis_tvalid,
   input logic                              m_axis_tready,
   input logic [fwd_pkg::META_OUT_BITS-1:0] user_metadata_out,
   input logic                              user_metadata_out_valid
);

   logic out_first;

   // Next egress beat opens a packet after tlast
   always_ff @(posedge axis_aclk or negedge arst_n) begin
      if (!arst_n) begin
         out_first <= 1'b1;
      end else if (m_axis_tvalid && m_axis_tready) begin
         out_first <= m_axis_tlast;
      end
   end

   // --------------------
   // Beat and sideband frozen under back-pressure
   stall_hold: assert property (@(posedge axis_aclk) disable iff (!arst_n)
      (m_axis_tvalid && !m_axis_tready) |=> (m_axis_tvalid && $stable(m_axis_tdata)
         && $stable(m_axis_tkeep) && $stable(m_axis_tlast)
         && $stable(user_metadata_out) && $stable(user_metadata_out_valid)))
      else $error("egress beat changed while stalled");

   // Metadata strobe only on a valid first beat
   meta_first: assert property (@(posedge axis_aclk) disable iff (!arst_n)
      user_metadata_out_valid == (m_axis_tvalid && out_first))
      else $error("egress metadata strobe not aligned with first beat");

   // Nothing leaves in the first cycle out of reset
   reset_quiet: assert property (@(posedge axis_aclk)
      $rose(arst_n) |-> (!m_axis_tvalid && !user_metadata_out_valid))
      else $error("egress valid high right after reset");

endmodule

bind p4_fwd_top p4_fwd_asserts #(
   .TDATA_NUM_BYTES (TDATA_NUM_BYTES)
) p4_fwd_asserts_inst (
   .axis_aclk               (axis_aclk),
   .arst_n                  (arst_n),
   .m_axis_tdata            (m_axis_tdata),
   .m_axis_tkeep            (m_axis_tkeep),
   .m_axis_tlast            (m_axis_tlast),
   .m_axis_tvalid           (m_axis_tvalid),
   .m_axis_tready           (m_axis_tready),
   .user_metadata_out       (user_metadata_out),
   .user_metadata_out_valid (user_metadata_out_valid)
);

// ==== verif/p4_fwd_tb.sv ====
// Directed packets with random egress back-pressure, checked against a queue scoreboard
// Payload byte i of a packet is start + i; the head byte carries the key in its low bits
`timescale 1ns/10ps

module p4_fwd_tb;

   import fwd_pkg::*;

   localparam int TDATA_NUM_BYTES = 4;
   localparam int KEY_BITS        = 4;
   localparam int FIFO_DEPTH      = 16;
   localparam int DW              = TDATA_NUM_BYTES * 8;
   localparam int NUM_ROWS        = 15;
   localparam int NUM_ENTRIES     = 5;

   logic                         axis_aclk = 1'b0;
   logic                         arst_n;
   logic [META_IN_BITS-1:0]      user_metadata_in;
   logic                         user_metadata_in_valid;
   logic [DW-1:0]                s_axis_tdata;
   logic [TDATA_NUM_BYTES-1:0]   s_axis_tkeep;
   logic                         s_axis_tlast;
   logic                         s_axis_tvalid;
   logic                         s_axis_tready;
   logic [DW-1:0]                m_axis_tdata;
   logic [TDATA_NUM_BYTES-1:0]   m_axis_tkeep;
   logic                         m_axis_tlast;
   logic                         m_axis_tvalid;
   logic                         m_axis_tready;
   logic [META_OUT_BITS-1:0]     user_metadata_out;
   logic                         user_metadata_out_valid;
   logic                         table_wr_en;
   logic [KEY_BITS-1:0]          table_wr_addr;
   fwd_action_e                  table_wr_action;
   logic [PORT_BITS-1:0]         table_wr_port;

   integer seed = 32'hf3bbb89a;
   int     cycles = 0;
   int     limit;
   int     rows_sent = 0;

   // Reference copy of what was programmed
   fwd_action_e          exp_act  [2**KEY_BITS];
   logic [PORT_BITS-1:0] exp_port [2**KEY_BITS];

   // Scoreboard, one entry per expected egress beat
   logic [DW-1:0]              exp_data  [$];
   logic [TDATA_NUM_BYTES-1:0] exp_keep  [$];
   logic                       exp_last  [$];
   logic                       exp_first [$];
   logic [META_OUT_BITS-1:0]   exp_meta  [$];

   p4_fwd_top #(
      .TDATA_NUM_BYTES (TDATA_NUM_BYTES),
      .KEY_BITS        (KEY_BITS),
      .FIFO_DEPTH      (FIFO_DEPTH)
   ) p4_fwd_top_inst (.*);

   always #5 axis_aclk = ~axis_aclk;

   // --------------------
   // Row is {key, ingress metadata, beats, start byte, keep of last beat}
   function automatic logic [31:0] stim_row(input int idx);
      case (idx)
         0:       return {4'h1, 8'h11, 8'd2, 8'h10, 4'hf};
         1:       return {4'h1, 8'h21, 8'd3, 8'h20, 4'h7};
         2:       return {4'h2, 8'h32, 8'd2, 8'h40, 4'hf};
         3:       return {4'h0, 8'h43, 8'd4, 8'h60, 4'hf};
         4:       return {4'h3, 8'h54, 8'd1, 8'h80, 4'h1};
         5:       return {4'h4, 8'h65, 8'd1, 8'h90, 4'h3};
         6:       return {4'h5, 8'h76, 8'd2, 8'ha0, 4'hf};
         7:       return {4'h1, 8'h87, 8'd8, 8'hb0, 4'hf};
         8:       return {4'h2, 8'h98, 8'd6, 8'hc0, 4'h1};
         9:       return {4'h3, 8'ha9, 8'd1, 8'hd0, 4'hf};
         10:      return {4'h4, 8'hba, 8'd5, 8'he0, 4'h7};
         11:      return {4'h7, 8'hcb, 8'd3, 8'hf0, 4'hf};
         12:      return {4'h1, 8'hdc, 8'd7, 8'h05, 4'hf};
         13:      return {4'h3, 8'hed, 8'd4, 8'h30, 4'h3};
         default: return {4'h2, 8'hfe, 8'd1, 8'h50, 4'hf};
      endcase
   endfunction

   // Entry is {address, action, port}; unlisted keys stay at drop
   function automatic logic [9:0] tbl_row(input int idx);
      case (idx)
         0:       return {4'h1, ACT_FORWARD, 4'h5};
         1:       return {4'h2, ACT_REWRITE, 4'h9};
         2:       return {4'h3, ACT_FORWARD, 4'hc};
         3:       return {4'h4, ACT_REWRITE, 4'ha};
         default: return {4'h5, ACT_DROP, 4'h3};
      endcase
   endfunction

   function automatic int total_beats();
      logic [31:0] row;
      int          sum;
      sum = 0;
      for (int i = 0; i < NUM_ROWS; i++) begin
         row = stim_row(i);
         sum += row[19:12];
      end
      return sum;
   endfunction

   // --------------------
   task automatic abort_run(input string reason);
      $display("%s", reason);
      $display("TEST FAILED");
      $fatal(1, "simulation stopped on first error");
   endtask

   task automatic report_mismatch(input string sig, input logic [31:0] got,
                                  input logic [31:0] want);
      abort_run($sformatf("FAIL %s got 0x%0h expected 0x%0h", sig, got, want));
   endtask

   task automatic program_table();
      logic [9:0] ent;
      for (int i = 0; i < NUM_ENTRIES; i++) begin
         ent             = tbl_row(i);
         table_wr_en     = 1'b1;
         table_wr_addr   = ent[9:6];
         table_wr_action = fwd_action_e'(ent[5:4]);
         table_wr_port   = ent[3:0];
         exp_act[ent[9:6]]  = fwd_action_e'(ent[5:4]);
         exp_port[ent[9:6]] = ent[3:0];
         @(negedge axis_aclk);
      end
      table_wr_en = 1'b0;
   endtask

   // Queues the expected egress beats, then drives the packet beat by beat
   task automatic send_packet(input int idx);
      logic [31:0]                row;
      logic [KEY_BITS-1:0]        key;
      logic [7:0]                 meta;
      logic [7:0]                 len;
      logic [7:0]                 start;
      logic [3:0]                 lkeep;
      logic [DW-1:0]              beat;
      logic [DW-1:0]              want;
      logic [TDATA_NUM_BYTES-1:0] keep;
      row = stim_row(idx);
      {key, meta, len, start, lkeep} = row;
      for (int n = 0; n < len; n++) begin
         for (int j = 0; j < TDATA_NUM_BYTES; j++) begin
            beat[j*8 +: 8] = start + 8'(n * TDATA_NUM_BYTES + j);
         end
         if (n == 0) beat[KEY_BITS-1:0] = key;
         keep = (n == len - 1) ? lkeep : '1;
         if (exp_act[key] != ACT_DROP) begin
            want = beat;
            // Rewrite puts the port into the key bits of the head byte
            if (n == 0 && exp_act[key] == ACT_REWRITE) want[KEY_BITS-1:0] = exp_port[key];
            exp_data.push_back(want);
            exp_keep.push_back(keep);
            exp_last.push_back(n == len - 1);
            exp_first.push_back(n == 0);
            exp_meta.push_back({exp_port[key], meta});
         end
         s_axis_tdata           = beat;
         s_axis_tkeep           = keep;
         s_axis_tlast           = (n == len - 1);
         s_axis_tvalid          = 1'b1;
         user_metadata_in       = (n == 0) ? meta : '0;
         user_metadata_in_valid = (n == 0);
         // tready depends only on DUT registers, so it holds until the next edge
         while (!s_axis_tready) @(negedge axis_aclk);
         @(negedge axis_aclk);
      end
      rows_sent++;
   endtask

   task automatic idle_inputs();
      s_axis_tvalid          = 1'b0;
      s_axis_tlast           = 1'b0;
      user_metadata_in_valid = 1'b0;
   endtask

   // --------------------
   // Egress ready and scoreboard, beat moves on the following rising edge
   always @(negedge axis_aclk) begin
      if (arst_n) begin
         m_axis_tready = ($random(seed) & 1) != 0;
         if (m_axis_tvalid && m_axis_tready) begin
            assert (exp_data.size() != 0)
               else abort_run("Egress beat arrived while no packet was expected");
            if (exp_data.size() != 0) begin
               assert (m_axis_tdata == exp_data[0])
                  else report_mismatch("m_axis_tdata", m_axis_tdata, exp_data[0]);
               assert (m_axis_tkeep == exp_keep[0])
                  else report_mismatch("m_axis_tkeep", m_axis_tkeep, exp_keep[0]);
               assert (m_axis_tlast == exp_last[0])
                  else report_mismatch("m_axis_tlast", m_axis_tlast, exp_last[0]);
               assert (user_metadata_out_valid == exp_first[0])
                  else report_mismatch("user_metadata_out_valid", user_metadata_out_valid,
                                       exp_first[0]);
               if (exp_first[0]) begin
                  assert (user_metadata_out == exp_meta[0])
                     else report_mismatch("user_metadata_out", user_metadata_out, exp_meta[0]);
               end
               void'(exp_data.pop_front());
               void'(exp_keep.pop_front());
               void'(exp_last.pop_front());
               void'(exp_first.pop_front());
               void'(exp_meta.pop_front());
            end
         end
      end
   end

   // Run limit scales with the traffic
   always @(posedge axis_aclk) begin
      cycles++;
      if (cycles > limit) begin
         abort_run($sformatf("Timeout after %0d cycles with %0d egress beats still pending",
                             cycles, exp_data.size()));
      end
   end

   // --------------------
   initial begin
      arst_n          = 1'b0;
      s_axis_tdata    = '0;
      s_axis_tkeep    = '0;
      user_metadata_in = '0;
      m_axis_tready   = 1'b0;
      table_wr_en     = 1'b0;
      table_wr_addr   = '0;
      table_wr_action = ACT_DROP;
      table_wr_port   = '0;
      idle_inputs();
      for (int k = 0; k < 2**KEY_BITS; k++) begin
         exp_act[k]  = ACT_DROP;
         exp_port[k] = '0;
      end
      limit = 4 * total_beats() + 200;
      repeat (3) @(negedge axis_aclk);
      arst_n = 1'b1;

      // Reset defaults
      @(negedge axis_aclk);
      assert (!m_axis_tvalid) else report_mismatch("m_axis_tvalid", m_axis_tvalid, 0);
      assert (!user_metadata_out_valid)
         else report_mismatch("user_metadata_out_valid", user_metadata_out_valid, 0);
      assert (s_axis_tready) else report_mismatch("s_axis_tready", s_axis_tready, 1);

      // Table still all drop, so this packet must vanish
      send_packet(0);
      idle_inputs();
      // Parser, FIFO and one pop per dropped beat fit well within this
      repeat (8) @(negedge axis_aclk);

      program_table();
      // Burst, more beats than the FIFO holds
      for (int r = 1; r < NUM_ROWS; r++) begin
         send_packet(r);
      end
      idle_inputs();

      while (exp_data.size() != 0) @(negedge axis_aclk);
      // Pipeline depth, any extra beat must have left or still sit on the output
      repeat (5) @(negedge axis_aclk);
      if (exp_data.size() == 0 && rows_sent == NUM_ROWS && !m_axis_tvalid) begin
         $display("TEST PASSED");
         $finish;
      end else begin
         abort_run("Egress still holds a beat after all expected traffic was taken");
      end
   end

endmodule
